// ==== compile.f ====
+incdir+src
src/albuf_pkg.sv
src/albuf_fill_if.sv
src/albuf_read_if.sv
src/albuf_fetch_req.sv
src/albuf_resp_fifo.sv
src/albuf_aligner.sv
src/albuf_top.sv
tests/albuf_tb.sv

// ==== src/albuf_aligner.sv ====
`timescale 1ns/1ps

module albuf_aligner (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        branch_i,
  input  logic [31:0] branch_addr_i,
  albuf_read_if.aligner rd,
  output logic        instr_valid_o,
  input  logic        instr_ready_i,
  output logic [31:0] instr_rdata_o,
  output logic [31:0] instr_addr_o,
  output logic        instr_err_o
);

  logic [31:0]            addr_q;
  albuf_pkg::resp_entry_t cur;
  albuf_pkg::resp_entry_t nxt;
  albuf_pkg::fetch_word_u spliced;
  logic                   cur_valid;
  logic                   both_valid;
  logic                   unaligned;
  logic                   al_comp;
  logic                   unal_comp;
  logic                   is_comp;
  logic                   emit;

  assign unaligned = addr_q[1];

  // Head word, or the incoming one when the FIFO is empty
  assign cur       = rd.head_valid ? rd.head_entry : rd.in_entry;
  assign cur_valid = rd.head_valid || rd.in_valid;
  // Word after it, from storage or straight from the bus
  assign nxt        = rd.next_valid ? rd.next_entry : rd.in_entry;
  assign both_valid = rd.next_valid || (rd.head_valid && rd.in_valid);

  // Compressed check on the halfword at the current address
  assign al_comp   = (cur.data.half.lo[1:0] != 2'b11);
  assign unal_comp = (cur.data.half.hi[1:0] != 2'b11);
  assign is_comp   = unaligned ? unal_comp : al_comp;

  // Straddling case: upper half of head below lower half of the next word
  always_comb begin
    spliced.half.lo = cur.data.half.hi;
    spliced.half.hi = nxt.data.half.lo;
  end

  //////////////////////////////////////////////////
  // Output toward the core
  //////////////////////////////////////////////////
  always_comb begin
    instr_rdata_o = cur.data.word;
    instr_err_o   = cur.err;
    instr_valid_o = cur_valid;
    if (unaligned) begin
      instr_rdata_o = spliced.word;
      // Uncompressed unaligned needs both words present
      if (!unal_comp) begin
        instr_err_o   = cur.err || nxt.err;
        instr_valid_o = both_valid;
      end
    end
    // Nothing leaves in the branch cycle
    if (branch_i) begin
      instr_valid_o = 1'b0;
    end
  end

  assign instr_addr_o    = addr_q;
  assign emit            = instr_valid_o && instr_ready_i;
  assign rd.emit         = emit;
  // Head is used up unless an aligned compressed leaves its upper half
  assign rd.release_head = emit && (unaligned || !al_comp);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (branch_i) begin
      addr_q <= {branch_addr_i[31:1], 1'b0};
    end else if (emit) begin
      addr_q <= addr_q + (is_comp ? 32'd2 : 32'd4);
    end
  end

endmodule

// ==== src/albuf_fetch_req.sv ====
`timescale 1ns/1ps
`include "albuf_macros.svh"

module albuf_fetch_req (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_req_i,
  input  logic        branch_i,
  input  logic [31:0] branch_addr_i,
  output logic        fetch_valid_o,
  input  logic        fetch_ready_i,
  output logic [31:0] fetch_addr_o,
  input  logic        resp_valid_i,
  input  logic [31:0] resp_rdata_i,
  input  logic        resp_err_i,
  output logic        busy_o,
  albuf_fill_if.requester fill
);

  logic [31:0]             addr_q;
  logic [31:0]             branch_word;
  logic [`ALBUF_CNT_W-1:0] outstnd_q;
  logic [`ALBUF_CNT_W-1:0] flush_q;
  logic                    accept;

  // Word address of the branch target
  assign branch_word = {branch_addr_i[31:2], 2'b00};

  // Fetch on a branch or when the buffer runs low, never past the limit
  assign fetch_valid_o = instr_req_i &&
                         (outstnd_q < `ALBUF_CNT_W'(`ALBUF_MAX_OUTSTND)) &&
                         (fill.fill_low || branch_i);
  assign accept        = fetch_valid_o && fetch_ready_i;
  // Redirect within the branch cycle
  assign fetch_addr_o  = branch_i ? branch_word : addr_q;
  assign busy_o        = (outstnd_q != '0) || fetch_valid_o;

  //////////////////////////////////////////////////
  // Towards the FIFO
  //////////////////////////////////////////////////
  // Stale responses and the one in the branch cycle are dropped
  assign fill.wr_valid            = resp_valid_i && (flush_q == '0) && !branch_i;
  assign fill.wr_entry.data.word  = resp_rdata_i;
  assign fill.wr_entry.err        = resp_err_i;
  assign fill.branch              = branch_i;
  assign fill.branch_unaligned    = branch_addr_i[1];
  assign fill.no_outstnd          = (outstnd_q == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q    <= '0;
      outstnd_q <= '0;
      flush_q   <= '0;
    end else begin
      // Next word after the one just requested
      if (accept) begin
        addr_q <= fetch_addr_o + 32'd4;
      end else if (branch_i) begin
        addr_q <= branch_word;
      end
      // One up per accepted request, one down per response
      outstnd_q <= outstnd_q + `ALBUF_CNT_W'(accept) - `ALBUF_CNT_W'(resp_valid_i);
      // Everything in flight at the branch gets discarded
      if (branch_i) begin
        flush_q <= outstnd_q - `ALBUF_CNT_W'(resp_valid_i);
      end else if (resp_valid_i && (flush_q != '0)) begin
        flush_q <= flush_q - 1'b1;
      end
    end
  end

endmodule

// ==== src/albuf_fill_if.sv ====
`timescale 1ns/1ps

interface albuf_fill_if;

  // Response to store, already gated while flushing
  logic                  wr_valid;
  albuf_pkg::resp_entry_t wr_entry;
  // Branch and its halfword alignment
  logic                  branch;
  logic                  branch_unaligned;
  // No fetch in flight
  logic                  no_outstnd;
  // Buffer is close to running dry
  logic                  fill_low;

  modport requester (
    output wr_valid, wr_entry, branch, branch_unaligned, no_outstnd,
    input  fill_low
  );

  modport fifo (
    input  wr_valid, wr_entry, branch, branch_unaligned, no_outstnd,
    output fill_low
  );

endinterface

// ==== src/albuf_macros.svh ====
`ifndef ALBUF_MACROS_SVH
`define ALBUF_MACROS_SVH

// Word entries in the response FIFO
`define ALBUF_DEPTH 3
// FIFO read and write pointer width
`define ALBUF_PTR_W 2
// Fetches allowed in flight at once
`define ALBUF_MAX_OUTSTND 2
// Outstanding and flush counter width
`define ALBUF_CNT_W 2
// Instruction count width, up to two per word
`define ALBUF_ICNT_W 3
`endif

// ==== src/albuf_pkg.sv ====
package albuf_pkg;

  // Two halfwords of a fetched word, hi at bits 31:16
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } half_pair_t;

  // One fetched word, seen whole or as two halfwords
  // Aligned instructions use the word view
  // Straddling instructions are spliced from the half view
  typedef union packed {
    logic [31:0] word;
    half_pair_t  half;
  } fetch_word_u;

  // One response as kept in the FIFO
  typedef struct packed {
    fetch_word_u data;
    logic        err;
  } resp_entry_t;

endpackage

// ==== src/albuf_read_if.sv ====
`timescale 1ns/1ps

interface albuf_read_if;

  // Word at the read pointer
  logic                   head_valid;
  albuf_pkg::resp_entry_t head_entry;
  // Word after the read pointer
  logic                   next_valid;
  albuf_pkg::resp_entry_t next_entry;
  // Response arriving this cycle, bypassed
  logic                   in_valid;
  albuf_pkg::resp_entry_t in_entry;
  // Instruction accepted downstream
  logic                   emit;
  // Head word fully consumed
  logic                   release_head;

  modport fifo (
    output head_valid, head_entry, next_valid, next_entry, in_valid, in_entry,
    input  emit, release_head
  );

  modport aligner (
    input  head_valid, head_entry, next_valid, next_entry, in_valid, in_entry,
    output emit, release_head
  );

endinterface

// ==== src/albuf_resp_fifo.sv ====
`timescale 1ns/1ps
`include "albuf_macros.svh"

module albuf_resp_fifo (
  input  logic clk,
  input  logic rst_n,
  albuf_fill_if.fifo  fill,
  albuf_read_if.fifo  rd
);

  albuf_pkg::resp_entry_t    entry_q [`ALBUF_DEPTH];
  logic [`ALBUF_DEPTH-1:0]   valid_q;
  logic [`ALBUF_DEPTH-1:0]   valid_n;
  logic [`ALBUF_PTR_W-1:0]   wptr_q;
  logic [`ALBUF_PTR_W-1:0]   rptr_q;
  logic [`ALBUF_PTR_W-1:0]   rptr2;
  logic [`ALBUF_ICNT_W-1:0]  icnt_q;
  logic [`ALBUF_ICNT_W-1:0]  icnt_adj;
  logic [1:0]                n_in;
  logic                      pop_q;
  logic                      aligned_q, aligned_n;
  logic                      complete_q, complete_n;
  logic                      lo_unc, hi_unc;

  // Ring increment with wrap at the last entry
  function automatic logic [`ALBUF_PTR_W-1:0] ptr_inc(input logic [`ALBUF_PTR_W-1:0] p);
    ptr_inc = (p == `ALBUF_PTR_W'(`ALBUF_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign rptr2 = ptr_inc(rptr_q);

  //////////////////////////////////////////////////
  // Read side, all combinational
  //////////////////////////////////////////////////
  assign rd.head_valid = valid_q[rptr_q];
  assign rd.head_entry = entry_q[rptr_q];
  assign rd.next_valid = valid_q[rptr2];
  assign rd.next_entry = entry_q[rptr2];
  assign rd.in_valid   = fill.wr_valid;
  assign rd.in_entry   = fill.wr_entry;

  // Set on write first, then the release clears, so a bypassed word is not kept
  always_comb begin
    valid_n = valid_q;
    if (fill.wr_valid) begin
      valid_n[wptr_q] = 1'b1;
    end
    if (rd.release_head) begin
      valid_n[rptr_q] = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Instruction count
  //////////////////////////////////////////////////
  assign lo_unc = (fill.wr_entry.data.half.lo[1:0] == 2'b11);
  assign hi_unc = (fill.wr_entry.data.half.hi[1:0] == 2'b11);

  // Complete instructions in the incoming word
  // Unaligned with complete set only follows an unaligned branch
  always_comb begin
    aligned_n  = aligned_q;
    complete_n = complete_q;
    n_in       = 2'd0;
    if (fill.branch) begin
      aligned_n  = !fill.branch_unaligned;
      complete_n = fill.branch_unaligned;
    end else if (fill.wr_valid) begin
      if (aligned_q && lo_unc) begin
        n_in = 2'd1;
      end else if (hi_unc) begin
        // Upper half starts an instruction that spills into the next word
        n_in       = (aligned_q || !complete_q) ? 2'd1 : 2'd0;
        aligned_n  = 1'b0;
        complete_n = 1'b0;
      end else begin
        n_in       = (!aligned_q && complete_q) ? 2'd1 : 2'd2;
        aligned_n  = 1'b1;
        complete_n = 1'b1;
      end
    end
  end

  // Pops come in one cycle late to keep instr_ready off this path
  assign icnt_adj      = icnt_q - `ALBUF_ICNT_W'(pop_q);
  assign fill.fill_low = (icnt_adj == '0) || ((icnt_adj == 'd1) && fill.no_outstnd);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q    <= '0;
      wptr_q     <= '0;
      rptr_q     <= '0;
      icnt_q     <= '0;
      pop_q      <= 1'b0;
      aligned_q  <= 1'b0;
      complete_q <= 1'b0;
    end else begin
      aligned_q  <= aligned_n;
      complete_q <= complete_n;
      pop_q      <= rd.emit && !fill.branch;
      if (fill.branch) begin
        valid_q <= '0;
        wptr_q  <= '0;
        rptr_q  <= '0;
        icnt_q  <= '0;
      end else begin
        valid_q <= valid_n;
        icnt_q  <= icnt_adj + `ALBUF_ICNT_W'(n_in);
        if (fill.wr_valid) begin
          wptr_q <= ptr_inc(wptr_q);
        end
        if (rd.release_head) begin
          rptr_q <= rptr2;
        end
      end
    end
  end

  // Word storage
  always_ff @(posedge clk) begin
    if (fill.wr_valid) begin
      entry_q[wptr_q] <= fill.wr_entry;
    end
  end

endmodule

// ==== src/albuf_top.sv ====
`timescale 1ns/1ps

module albuf_top (
  input  logic        clk,
  input  logic        rst_n,
  // Control
  input  logic        instr_req_i,
  input  logic        branch_i,
  input  logic [31:0] branch_addr_i,
  output logic        busy_o,
  // Fetch requests
  output logic        fetch_valid_o,
  input  logic        fetch_ready_i,
  output logic [31:0] fetch_addr_o,
  // Fetch responses, in order and never stalled
  input  logic        resp_valid_i,
  input  logic [31:0] resp_rdata_i,
  input  logic        resp_err_i,
  // Instructions out
  output logic        instr_valid_o,
  input  logic        instr_ready_i,
  output logic [31:0] instr_rdata_o,
  output logic [31:0] instr_addr_o,
  output logic        instr_err_o
);

  albuf_fill_if fill_bus ();
  albuf_read_if rd_bus ();

  // Requests, outstanding count and flush of stale words
  albuf_fetch_req fetch_req_i (
    .clk, .rst_n, .instr_req_i, .branch_i, .branch_addr_i,
    .fetch_valid_o, .fetch_ready_i, .fetch_addr_o,
    .resp_valid_i, .resp_rdata_i, .resp_err_i, .busy_o,
    .fill (fill_bus.requester)
  );

  // Three-word store with bypass
  albuf_resp_fifo resp_fifo_i (
    .clk, .rst_n,
    .fill (fill_bus.fifo),
    .rd   (rd_bus.fifo)
  );

  // Halfword-addressed instruction extraction
  albuf_aligner aligner_i (
    .clk, .rst_n, .branch_i, .branch_addr_i,
    .rd (rd_bus.aligner),
    .instr_valid_o, .instr_ready_i, .instr_rdata_o, .instr_addr_o, .instr_err_o
  );

endmodule

// ==== tests/albuf_tb.sv ====
`timescale 1ns/1ps
`include "albuf_macros.svh"

module albuf_tb;

  logic        clk, rst_n, instr_req_i, branch_i, busy_o;
  logic [31:0] branch_addr_i, fetch_addr_o, resp_rdata_i;
  logic        fetch_valid_o, fetch_ready_i, resp_valid_i, resp_err_i;
  logic        instr_valid_o, instr_ready_i, instr_err_o;
  logic [31:0] instr_rdata_o, instr_addr_o;

  // Memory model, indexed by word address bits 7:2
  logic [31:0] mem [64];
  logic        err_mem [64];
  // Accepted fetches waiting for their response, in order
  logic [31:0] pend_addr [$];
  int          pend_due [$];
  int          cyc, last_due, emitted, straddled, traffic_branches, error_count;
  int          fetch_pct, instr_pct, branch_pct, rand_seed, first_draw;
  logic [31:0] exp_fetch, walk_addr;
  bit          req_en, delivered;
  string       test_name;

  albuf_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Failure reporting and compare tasks
  //////////////////////////////////////////////////
  task automatic stop_on_error();
    error_count++;
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("mismatch %s address: expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  // Compressed instructions only own the low halfword
  task automatic compare_word(input string name, input albuf_pkg::fetch_word_u exp,
                              input albuf_pkg::fetch_word_u act, input bit comp);
    logic ok;
    ok = comp ? (act.half.lo === exp.half.lo) : (act.word === exp.word);
    if (!ok) begin
      $display("mismatch %s instruction (compressed %0d): expected %h, actual %h",
               name, comp, exp.word, act.word);
      stop_on_error();
    end
  endtask

  task automatic verify_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s error: expected %b, actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  //////////////////////////////////////////////////
  // Reference instruction walker
  //////////////////////////////////////////////////
  function automatic logic [15:0] half_at(input logic [31:0] a);
    logic [31:0] w;
    w = mem[a[7:2]];
    half_at = a[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic logic err_bit_at(input logic [31:0] a);
    err_bit_at = err_mem[a[7:2]];
  endfunction

  task automatic walk_instr();
    albuf_pkg::fetch_word_u exp_w;
    albuf_pkg::fetch_word_u act_w;
    logic                   exp_e;
    bit                     comp;
    exp_w.half.lo = half_at(walk_addr);
    comp          = (exp_w.half.lo[1:0] != 2'b11);
    // Uncompressed takes the next halfword too, maybe from the next word
    exp_w.half.hi = comp ? 16'h0000 : half_at(walk_addr + 32'd2);
    exp_e         = err_bit_at(walk_addr) || (!comp && err_bit_at(walk_addr + 32'd2));
    act_w         = instr_rdata_o;
    check_addr(test_name, walk_addr, instr_addr_o);
    compare_word(test_name, exp_w, act_w, comp);
    verify_err(test_name, exp_e, instr_err_o);
    if (walk_addr[1] && !comp) begin
      straddled++;
    end
    walk_addr = walk_addr + (comp ? 32'd2 : 32'd4);
    emitted++;
  endtask

  //////////////////////////////////////////////////
  // One clock cycle of stimulus and checking
  //////////////////////////////////////////////////
  // Align mode 0 random, 1 word aligned, 2 halfword unaligned
  task automatic run_cycle(input bit force_br, input int align_mode);
    bit          br;
    logic [31:0] baddr, a;
    int          outstanding, due;
    @(negedge clk);
    cyc++;
    br    = force_br || ($urandom_range(99, 0) < branch_pct);
    baddr = $urandom;
    if (align_mode != 0) begin
      baddr[1] = (align_mode == 2);
    end
    branch_i      = br;
    branch_addr_i = baddr;
    instr_req_i   = req_en;
    fetch_ready_i = ($urandom_range(99, 0) < fetch_pct);
    instr_ready_i = ($urandom_range(99, 0) < instr_pct);
    // Bus returns the oldest fetch once its delay is up, even if stale
    delivered     = (pend_addr.size() > 0) && (pend_due[0] <= cyc);
    resp_valid_i  = delivered;
    resp_rdata_i  = $urandom;
    resp_err_i    = 1'b0;
    if (delivered) begin
      a            = pend_addr.pop_front();
      due          = pend_due.pop_front();
      resp_rdata_i = mem[a[7:2]];
      resp_err_i   = err_mem[a[7:2]];
    end
    // Outputs are settled well before the rising edge
    #5;
    outstanding = pend_addr.size() + delivered;
    if (fetch_valid_o && outstanding >= `ALBUF_MAX_OUTSTND) begin
      $display("fetch requested while %0d fetches are outstanding", outstanding);
      stop_on_error();
    end
    if (br) begin
      exp_fetch = {baddr[31:2], 2'b00};
      if (outstanding > 0) begin
        traffic_branches++;
      end
    end
    if (fetch_valid_o && fetch_ready_i) begin
      check_addr(test_name, exp_fetch, fetch_addr_o);
      due = cyc + $urandom_range(4, 1);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      pend_addr.push_back(exp_fetch);
      pend_due.push_back(due);
      exp_fetch = exp_fetch + 32'd4;
    end
    if (br) begin
      if (instr_valid_o) begin
        $display("instruction offered in a branch cycle");
        stop_on_error();
      end
      walk_addr = {baddr[31:1], 1'b0};
    end else if (instr_valid_o && instr_ready_i) begin
      walk_instr();
    end
  endtask

  task automatic collect_instrs(input int count, input int limit);
    int target, waited;
    target = emitted + count;
    waited = 0;
    while (emitted < target) begin
      if (waited >= limit) begin
        $display("timeout in %s waiting for %0d instructions", test_name, count);
        stop_on_error();
      end else begin
        run_cycle(1'b0, 0);
        waited++;
      end
    end
  endtask

  task automatic drain_responses(input int limit);
    int waited;
    waited = 0;
    while (pend_addr.size() > 0 || delivered) begin
      if (waited >= limit) begin
        $display("timeout in %s waiting for outstanding responses", test_name);
        stop_on_error();
      end else begin
        run_cycle(1'b0, 0);
        waited++;
      end
    end
  endtask

  // Random halfwords, about half of them uncompressed, rare word errors
  task automatic fill_memory();
    logic [15:0] h [2];
    for (int i = 0; i < 64; i++) begin
      for (int j = 0; j < 2; j++) begin
        h[j] = $urandom;
        h[j][1:0] = $urandom_range(1, 0) ? 2'b11 : 2'($urandom_range(2, 0));
      end
      mem[i]     = {h[1], h[0]};
      err_mem[i] = ($urandom_range(7, 0) == 0);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    rand_seed  = 32'h6a0c_c7ac;
    first_draw = $urandom(rand_seed);
    {rst_n, instr_req_i, branch_i, fetch_ready_i, resp_valid_i, resp_err_i} = '0;
    {branch_addr_i, resp_rdata_i, instr_ready_i} = '0;
    {cyc, last_due, emitted, straddled, traffic_branches, error_count} = '0;
    {req_en, delivered, exp_fetch, walk_addr} = '0;
    {fetch_pct, instr_pct, branch_pct} = '0;
    fill_memory();
    // Two rising edges in reset, release on the falling edge after them
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #5;
    test_name = "reset";
    if (fetch_valid_o || instr_valid_o || busy_o) begin
      $display("fetch_valid_o, instr_valid_o or busy_o high after reset");
      stop_on_error();
    end
    check_addr(test_name, 32'h0, fetch_addr_o);
    // Aligned branch, then a long in-order stream
    test_name = "branch_sequence";
    {req_en, fetch_pct, instr_pct} = {1'b1, 32'd70, 32'd70};
    run_cycle(1'b1, 1);
    collect_instrs(80, 1000);
    test_name = "unaligned_straddle";
    repeat (8) begin
      run_cycle(1'b1, 2);
      collect_instrs(12, 300);
    end
    if (straddled == 0) begin
      $display("no uncompressed instruction straddled two words");
      stop_on_error();
    end
    // Random branches while fetches are in flight
    test_name = "branch_under_traffic";
    {branch_pct, fetch_pct, instr_pct} = {32'd6, 32'd90, 32'd80};
    repeat (400) run_cycle(1'b0, 0);
    branch_pct = 0;
    if (traffic_branches == 0) begin
      $display("no branch was taken with fetches in flight");
      stop_on_error();
    end
    collect_instrs(20, 300);
    // Consumer stalls long enough for the FIFO to fill
    test_name = "back_pressure";
    {instr_pct, fetch_pct} = {32'd0, 32'd100};
    repeat (40) run_cycle(1'b0, 0);
    instr_pct = 100;
    collect_instrs(30, 300);
    test_name = "idle_busy";
    {req_en, instr_pct} = {1'b0, 32'd70};
    drain_responses(50);
    if (busy_o !== 1'b0) begin
      $display("busy_o high with fetching off and no response outstanding");
      stop_on_error();
    end
    if (error_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1, "errors were recorded");
    end
  end

endmodule
